/* constExtract.sv */
/* Immediate extraction, constant-present flag and instruction length.
   Stores split the constant around the source register field. */
`timescale 1ns/10ps
`include "idec_defines.svh"

module constExtract
(
    input  logic [`INSN_W-1:0]  instr_i,
    input  logic                isStore_i,
    output logic [`CONST_W-1:0] const_o,
    output logic                hasConst_o,
    output logic [`LEN_W-1:0]   len_o
);

    localparam int WideW   = 30;
    localparam int NarrowW = 14;

    logic [WideW-1:0]   wideImm;
    logic [NarrowW-1:0] narrowImm;
    logic               longForm;

    // Bit 6 set selects the 48-bit form with the wide constant
    assign longForm  = instr_i[`L2_LO];
    assign wideImm   = isStore_i ? {instr_i[47:23], instr_i[17:13]} : instr_i[47:18];
    assign narrowImm = isStore_i ? {instr_i[31:23], instr_i[17:13]} : instr_i[31:18];

    assign const_o = longForm ? {{(`CONST_W-WideW){wideImm[WideW-1]}}, wideImm}
                              : {{(`CONST_W-NarrowW){narrowImm[NarrowW-1]}}, narrowImm};

    always_comb
    begin
        case (idec_pkg::opcode_e'(instr_i[`OP_HI:`OP_LO]))
            idec_pkg::ADDI, idec_pkg::MULI, idec_pkg::DIVI, idec_pkg::ANDI,
            idec_pkg::ORI, idec_pkg::XORI, idec_pkg::LB, idec_pkg::LBU,
            idec_pkg::Lx, idec_pkg::SB, idec_pkg::Sx, idec_pkg::INC,
            idec_pkg::CAS, idec_pkg::JAL, idec_pkg::CALL, idec_pkg::RET:
                hasConst_o = 1'b1;
            default:
                hasConst_o = 1'b0;
        endcase
    end

    // Length in parcels of 8 bits
    always_comb
    begin
        case (instr_i[`L2_HI:`L2_LO])
            2'b00:   len_o = `LEN_W'(4);
            2'b01:   len_o = `LEN_W'(6);
            default: len_o = `LEN_W'(2);
        endcase
    end

endmodule

/* idec_defines.svh */
/* Width and field-position macros for the instruction decode stage.
   Included by every decoder module that slices the instruction word. */

`ifndef IDEC_DEFINES_SVH
`define IDEC_DEFINES_SVH

// Datapath widths
`define INSN_W  48
`define ID_W    5
`define REG_W   5
`define CONST_W 64
`define LEN_W   3

// Primary opcode
`define OP_HI   5
`define OP_LO   0

// Length code, 00 marks the base 32-bit form
`define L2_HI   7
`define L2_LO   6

// Function code of R2 and MEMNDX forms
`define S2_HI   31
`define S2_LO   26

// Sub-op of the R1 group
`define R1_HI   22
`define R1_LO   18

`endif

/* idec_pkg.sv */
/* Opcode, function-code and access-size types shared by the decoders.
   Referenced with scoped names from each module that needs them. */

package idec_pkg;

    // =========================================================================
    // Primary opcodes, anything not listed decodes as "other"
    // =========================================================================
    typedef enum logic [5:0]
    {
        BRK    = 6'h00,
        R2     = 6'h02,
        ADDI   = 6'h04,
        CSRRW  = 6'h05,
        MULI   = 6'h06,
        DIVI   = 6'h07,
        ANDI   = 6'h08,
        ORI    = 6'h09,
        XORI   = 6'h0A,
        FLOAT  = 6'h0F,
        LB     = 6'h13,
        SB     = 6'h15,
        MEMNDX = 6'h16,
        JAL    = 6'h18,
        INC    = 6'h1A,
        Lx     = 6'h20,
        LBU    = 6'h23,
        Sx     = 6'h24,
        LUI    = 6'h27,
        JMP    = 6'h28,
        CALL   = 6'h29,
        RET    = 6'h2A,
        CAS    = 6'h2C,
        Bcc    = 6'h30,
        BEQI   = 6'h32
    } opcode_e;

    // Register-register function codes
    typedef enum logic [5:0]
    {
        R1 = 6'h01, ADD = 6'h04, SUB = 6'h05, AND = 6'h08, OR = 6'h09,
        XOR = 6'h0A, SEI = 6'h11, RTI = 6'h13, MIN = 6'h2C, MAX = 6'h2D,
        SHIFTR = 6'h2F, MUL = 6'h3A, DIV = 6'h3E
    } r2Funct_e;

    // Indexed load/store function codes
    typedef enum logic [5:0]
    {
        LBX = 6'h00, LBUX = 6'h01, LCX = 6'h02, LHX = 6'h04, LWX = 6'h06,
        SBX = 6'h10, SCX = 6'h11, SHX = 6'h12, SWX = 6'h13, CASX = 6'h18
    } ndxFunct_e;

    // R1 group sub-ops
    typedef enum logic [4:0]
    {
        SYNC = 5'h06
    } r1Op_e;

    // =========================================================================
    // Memory access size
    // =========================================================================
    typedef enum logic [2:0]
    {
        BYTE  = 3'd0,
        WYDE  = 3'd1,
        TETRA = 3'd2,
        OCTA  = 3'd3
    } memSize_e;

endpackage

/* instrDecoder.sv */
/* Instruction decode stage top level. Decodes one instruction per cycle
   and presents every field registered, one clock after idv_i. */
`timescale 1ns/10ps
`include "idec_defines.svh"

module instrDecoder
(
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                idv_i,
    input  logic [`ID_W-1:0]    id_i,
    input  logic [`INSN_W-1:0]  instr_i,
    input  logic [`REG_W-1:0]   rt_i,
    output logic                idv_o,
    output logic [`ID_W-1:0]    id_o,
    output logic                isAlu_o, alu0Only_o, isFpu_o, flowCtrl_o,
    output logic                isBranch_o, isJmp_o, isJal_o, isRet_o,
    output logic                isBrk_o, isIrq_o, isRti_o, branchTarget_o,
    output logic                isSync_o, isSei_o,
    output logic                isLoad_o, isStore_o, isMem_o, isMemNdx_o, isRmw_o,
    output idec_pkg::memSize_e  memSize_o,
    output logic [`CONST_W-1:0] const_o,
    output logic                hasConst_o,
    output logic [`LEN_W-1:0]   len_o,
    output logic                regFileWrite_o, preload_o
);

    localparam int NumFlags = 22;

    logic isAluNxt, alu0OnlyNxt, isFpuNxt, flowCtrlNxt, isBranchNxt, isJmpNxt;
    logic isJalNxt, isRetNxt, isBrkNxt, isIrqNxt, isRtiNxt, branchTargetNxt;
    logic isSyncNxt, isSeiNxt, aluWriteNxt;
    logic isLoadNxt, isStoreNxt, isMemNxt, isMemNdxNxt, isRmwNxt, memWriteNxt;
    logic hasConstNxt, regFileWriteNxt, preloadNxt;

    idec_pkg::memSize_e  memSizeNxt;
    logic [`CONST_W-1:0] constNxt;
    logic [`LEN_W-1:0]   lenNxt;
    logic [NumFlags-1:0] flagsNxt;
    logic [NumFlags-1:0] flagsQ;

    // =========================================================================
    // Decoders
    // =========================================================================
    opClassify u_opClassify
    (
        .instr_i       (instr_i),
        .isAlu_o       (isAluNxt),      .alu0Only_o   (alu0OnlyNxt),
        .isFpu_o       (isFpuNxt),      .flowCtrl_o   (flowCtrlNxt),
        .isBranch_o    (isBranchNxt),   .isJmp_o      (isJmpNxt),
        .isJal_o       (isJalNxt),      .isRet_o      (isRetNxt),
        .isBrk_o       (isBrkNxt),      .isIrq_o      (isIrqNxt),
        .isRti_o       (isRtiNxt),      .branchTarget_o (branchTargetNxt),
        .isSync_o      (isSyncNxt),     .isSei_o      (isSeiNxt),
        .aluWrite_o    (aluWriteNxt)
    );

    memDecode u_memDecode
    (
        .instr_i       (instr_i),
        .isLoad_o      (isLoadNxt),     .isStore_o    (isStoreNxt),
        .isMem_o       (isMemNxt),      .isMemNdx_o   (isMemNdxNxt),
        .isRmw_o       (isRmwNxt),      .memWrite_o   (memWriteNxt),
        .memSize_o     (memSizeNxt)
    );

    constExtract u_constExtract
    (
        .instr_i       (instr_i),
        .isStore_i     (isStoreNxt),
        .const_o       (constNxt),
        .hasConst_o    (hasConstNxt),
        .len_o         (lenNxt)
    );

    // Writes to r0 are dropped, a load to r0 only warms the cache
    assign regFileWriteNxt = (aluWriteNxt || memWriteNxt) && (rt_i != '0);
    assign preloadNxt      = isLoadNxt && (rt_i == '0);

    assign flagsNxt = {isAluNxt, alu0OnlyNxt, isFpuNxt, flowCtrlNxt, isBranchNxt,
                       isJmpNxt, isJalNxt, isRetNxt, isBrkNxt, isIrqNxt, isRtiNxt,
                       branchTargetNxt, isSyncNxt, isSeiNxt, isLoadNxt, isStoreNxt,
                       isMemNxt, isMemNdxNxt, isRmwNxt, hasConstNxt, regFileWriteNxt,
                       preloadNxt};

    // =========================================================================
    // Output register
    // =========================================================================
    always_ff @(posedge clk)
    begin
        if (!rstN_i)
        begin
            idv_o     <= 1'b0;
            id_o      <= '0;
            flagsQ    <= '0;
            memSize_o <= idec_pkg::BYTE;
            const_o   <= '0;
            len_o     <= '0;
        end
        else
        begin
            // Fields follow instr_i even when idv_i is low
            idv_o     <= idv_i;
            id_o      <= id_i;
            flagsQ    <= flagsNxt;
            memSize_o <= memSizeNxt;
            const_o   <= constNxt;
            len_o     <= lenNxt;
        end
    end

    assign {isAlu_o, alu0Only_o, isFpu_o, flowCtrl_o, isBranch_o, isJmp_o, isJal_o,
            isRet_o, isBrk_o, isIrq_o, isRti_o, branchTarget_o, isSync_o, isSei_o,
            isLoad_o, isStore_o, isMem_o, isMemNdx_o, isRmw_o, hasConst_o,
            regFileWrite_o, preload_o} = flagsQ;

endmodule

/* list.f */
+incdir+.
idec_pkg.sv
opClassify.sv
memDecode.sv
constExtract.sv
instrDecoder.sv
tb_instrDecoder.sv

/* memDecode.sv */
/* Load, store and read-modify-write detection plus access-size decode.
   Combinational; isStore also steers the constant layout. */
`timescale 1ns/10ps
`include "idec_defines.svh"

module memDecode
(
    input  logic [`INSN_W-1:0] instr_i,
    output logic               isLoad_o, isStore_o, isMem_o,
    output logic               isMemNdx_o, isRmw_o, memWrite_o,
    output idec_pkg::memSize_e memSize_o
);

    idec_pkg::opcode_e   opcode;
    idec_pkg::ndxFunct_e ndxFunct;
    logic                len0Ndx;
    logic                ndxLoad;
    logic                ndxStore;
    logic                ndxCas;
    idec_pkg::memSize_e  ndxSize;

    // Size code of the Lx and Sx forms
    function automatic idec_pkg::memSize_e sizeFromBits(input logic [2:0] sizeBits);
        casez (sizeBits)
            3'b100:  return idec_pkg::OCTA;
            3'b?10:  return idec_pkg::TETRA;
            3'b??1:  return idec_pkg::WYDE;
            default: return idec_pkg::OCTA;
        endcase
    endfunction

    assign opcode   = idec_pkg::opcode_e'(instr_i[`OP_HI:`OP_LO]);
    assign ndxFunct = idec_pkg::ndxFunct_e'(instr_i[`S2_HI:`S2_LO]);
    assign len0Ndx  = (opcode == idec_pkg::MEMNDX) && (instr_i[`L2_HI:`L2_LO] == 2'b00);

    // =========================================================================
    // Indexed forms
    // =========================================================================
    always_comb
    begin
        ndxLoad  = 1'b0;
        ndxStore = 1'b0;
        ndxCas   = 1'b0;
        ndxSize  = idec_pkg::OCTA;
        case (ndxFunct)
            idec_pkg::LBX, idec_pkg::LBUX:
            begin
                ndxLoad = 1'b1;
                ndxSize = idec_pkg::BYTE;
            end
            idec_pkg::LCX:
            begin
                ndxLoad = 1'b1;
                ndxSize = idec_pkg::WYDE;
            end
            idec_pkg::LHX:
            begin
                ndxLoad = 1'b1;
                ndxSize = idec_pkg::TETRA;
            end
            idec_pkg::LWX:
                ndxLoad = 1'b1;
            idec_pkg::SBX:
            begin
                ndxStore = 1'b1;
                ndxSize  = idec_pkg::BYTE;
            end
            idec_pkg::SCX:
            begin
                ndxStore = 1'b1;
                ndxSize  = idec_pkg::WYDE;
            end
            idec_pkg::SHX:
            begin
                ndxStore = 1'b1;
                ndxSize  = idec_pkg::TETRA;
            end
            idec_pkg::SWX:
                ndxStore = 1'b1;
            idec_pkg::CASX:
            begin
                ndxStore = 1'b1;
                ndxCas   = 1'b1;
            end
            default:
                ndxSize = idec_pkg::OCTA;
        endcase
    end

    // =========================================================================
    // Direct forms
    // =========================================================================
    always_comb
    begin
        isLoad_o  = 1'b0;
        isStore_o = 1'b0;
        isMem_o   = 1'b1;
        memSize_o = idec_pkg::OCTA;
        case (opcode)
            idec_pkg::LB, idec_pkg::LBU:
            begin
                isLoad_o  = 1'b1;
                memSize_o = idec_pkg::BYTE;
            end
            idec_pkg::Lx:
            begin
                isLoad_o  = 1'b1;
                memSize_o = sizeFromBits(instr_i[20:18]);
            end
            idec_pkg::SB:
            begin
                isStore_o = 1'b1;
                memSize_o = idec_pkg::BYTE;
            end
            idec_pkg::Sx:
            begin
                isStore_o = 1'b1;
                memSize_o = sizeFromBits(instr_i[15:13]);
            end
            idec_pkg::INC, idec_pkg::CAS:
                isStore_o = 1'b1;
            // Longer indexed forms are memory ops with no further decode
            idec_pkg::MEMNDX:
            begin
                isLoad_o  = len0Ndx && ndxLoad;
                isStore_o = len0Ndx && ndxStore;
                memSize_o = len0Ndx ? ndxSize : idec_pkg::OCTA;
            end
            default:
                isMem_o = 1'b0;
        endcase
    end

    assign isMemNdx_o = (opcode == idec_pkg::MEMNDX);
    assign isRmw_o    = (opcode == idec_pkg::CAS) || (opcode == idec_pkg::INC)
                        || (len0Ndx && ndxCas);
    // CAS returns the old memory value to the target register
    assign memWrite_o = isLoad_o || (opcode == idec_pkg::CAS) || (len0Ndx && ndxCas);

endmodule

/* opClassify.sv */
/* Functional-unit class and flow-control decode of one instruction.
   Combinational; instrDecoder registers the results. */
`timescale 1ns/10ps
`include "idec_defines.svh"

module opClassify
(
    input  logic [`INSN_W-1:0] instr_i,
    output logic               isAlu_o, alu0Only_o, isFpu_o, flowCtrl_o,
    output logic               isBranch_o, isJmp_o, isJal_o, isRet_o,
    output logic               isBrk_o, isIrq_o, isRti_o, branchTarget_o,
    output logic               isSync_o, isSei_o, aluWrite_o
);

    idec_pkg::opcode_e  opcode;
    idec_pkg::r2Funct_e funct;
    idec_pkg::r1Op_e    r1Op;
    logic               isLen0;
    logic               isR2;
    logic               len0R2;
    logic               r2Alu0;
    logic               r2Write;

    assign opcode = idec_pkg::opcode_e'(instr_i[`OP_HI:`OP_LO]);
    assign funct  = idec_pkg::r2Funct_e'(instr_i[`S2_HI:`S2_LO]);
    assign r1Op   = idec_pkg::r1Op_e'(instr_i[`R1_HI:`R1_LO]);
    assign isLen0 = (instr_i[`L2_HI:`L2_LO] == 2'b00);
    assign isR2   = (opcode == idec_pkg::R2);
    assign len0R2 = isR2 && isLen0;

    // =========================================================================
    // Control transfer
    // =========================================================================
    assign isBrk_o    = (opcode == idec_pkg::BRK);
    // Software break with a zero cause field is an interrupt
    assign isIrq_o    = isBrk_o && (instr_i[23:20] == 4'h0);
    assign isRti_o    = isR2 && (funct == idec_pkg::RTI);
    assign isJmp_o    = (opcode == idec_pkg::JMP);
    assign isJal_o    = (opcode == idec_pkg::JAL);
    assign isRet_o    = (opcode == idec_pkg::RET);
    assign isBranch_o = (opcode == idec_pkg::Bcc) || (opcode == idec_pkg::BEQI);

    // Targets not known at fetch, the branch target buffer learns these
    assign branchTarget_o = isJal_o || isRet_o || isBrk_o || isRti_o;

    assign isSync_o = (len0R2 && (funct == idec_pkg::R1) && (r1Op == idec_pkg::SYNC))
                      || isBrk_o || isRti_o;
    assign isSei_o  = len0R2 && (funct == idec_pkg::SEI);

    always_comb
    begin
        case (opcode)
            idec_pkg::BRK, idec_pkg::Bcc, idec_pkg::BEQI, idec_pkg::JAL,
            idec_pkg::JMP, idec_pkg::CALL, idec_pkg::RET:
                flowCtrl_o = 1'b1;
            default:
                flowCtrl_o = isRti_o;
        endcase
    end

    // =========================================================================
    // Unit class and register write
    // =========================================================================
    assign isFpu_o = (opcode == idec_pkg::FLOAT);
    // Flow control and float ops are the only ones kept off the ALUs
    assign isAlu_o = !(flowCtrl_o || isFpu_o);

    // R2 functs that need ALU0 or write a result
    always_comb
    begin
        r2Alu0  = 1'b0;
        r2Write = 1'b0;
        case (funct)
            idec_pkg::MUL, idec_pkg::DIV, idec_pkg::MIN, idec_pkg::MAX,
            idec_pkg::R1, idec_pkg::SHIFTR:
            begin
                r2Alu0  = 1'b1;
                r2Write = 1'b1;
            end
            idec_pkg::ADD, idec_pkg::SUB, idec_pkg::AND, idec_pkg::OR,
            idec_pkg::XOR, idec_pkg::SEI:
                r2Write = 1'b1;
            default:
                r2Write = 1'b0;
        endcase
    end

    always_comb
    begin
        alu0Only_o = 1'b0;
        aluWrite_o = 1'b0;
        case (opcode)
            idec_pkg::R2:
            begin
                alu0Only_o = isLen0 && r2Alu0;
                aluWrite_o = isLen0 && r2Write;
            end
            idec_pkg::MEMNDX:
                alu0Only_o = 1'b1;
            idec_pkg::MULI, idec_pkg::DIVI, idec_pkg::CSRRW:
            begin
                alu0Only_o = 1'b1;
                aluWrite_o = 1'b1;
            end
            idec_pkg::ADDI, idec_pkg::ANDI, idec_pkg::ORI, idec_pkg::XORI,
            idec_pkg::JAL, idec_pkg::CALL, idec_pkg::RET, idec_pkg::LUI:
                aluWrite_o = 1'b1;
            default:
                aluWrite_o = 1'b0;
        endcase
    end

endmodule

/* tb_decodeModel.svh */
/* Reference decode model and xorshift random source for the decode testbench.
   Included inside the testbench module, after the width macros. */

`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Expected output set of one decoded instruction
// Flag order, msb first: isAlu alu0Only isFpu flowCtrl isBranch isJmp isJal isRet
// isBrk isIrq isRti branchTarget isSync isSei isLoad isStore isMem isMemNdx isRmw
// hasConst regFileWrite preload
typedef struct packed
{
    logic                idv;
    logic [`ID_W-1:0]    id;
    logic [21:0]         flags;
    logic [2:0]          size;
    logic [`CONST_W-1:0] konst;
    logic [`LEN_W-1:0]   len;
} expect_t;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Membership test against up to sixteen packed 6-bit codes
function automatic bit inList(input logic [5:0] v, input logic [95:0] list, input int n);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < n; i++)
        if (list[i*6 +: 6] == v)
            hit = 1'b1;
    return hit;
endfunction

function automatic bit modelStore(input logic [`INSN_W-1:0] ins);
    logic [5:0] op;
    logic [5:0] fn;
    bit         ndx0;
    op   = ins[`OP_HI:`OP_LO];
    fn   = ins[`S2_HI:`S2_LO];
    ndx0 = (op == idec_pkg::MEMNDX) && (ins[`L2_HI:`L2_LO] == 2'b00);
    return inList(op, {idec_pkg::SB, idec_pkg::Sx, idec_pkg::INC, idec_pkg::CAS}, 4)
           || (ndx0 && inList(fn, {idec_pkg::SBX, idec_pkg::SCX, idec_pkg::SHX,
                                   idec_pkg::SWX, idec_pkg::CASX}, 5));
endfunction

function automatic logic [21:0] modelFlags(input logic [`INSN_W-1:0] ins,
                                           input logic [`REG_W-1:0] rt);
    logic [5:0] op;
    logic [5:0] fn;
    bit         len0, r2, rti, brk, jal, ret, flow, alu, alu0, sync, sei;
    bit         aluWr, ndx0, load, store, mem, casx, rmw, memWr, konst;
    op    = ins[`OP_HI:`OP_LO];
    fn    = ins[`S2_HI:`S2_LO];
    len0  = (ins[`L2_HI:`L2_LO] == 2'b00);
    r2    = (op == idec_pkg::R2);
    rti   = r2 && (fn == idec_pkg::RTI);
    brk   = (op == idec_pkg::BRK);
    jal   = (op == idec_pkg::JAL);
    ret   = (op == idec_pkg::RET);
    flow  = rti || inList(op, {idec_pkg::BRK, idec_pkg::Bcc, idec_pkg::BEQI, idec_pkg::JAL,
                               idec_pkg::JMP, idec_pkg::CALL, idec_pkg::RET}, 7);
    alu   = !(rti || inList(op, {idec_pkg::BRK, idec_pkg::Bcc, idec_pkg::BEQI, idec_pkg::JAL,
                                 idec_pkg::JMP, idec_pkg::CALL, idec_pkg::RET,
                                 idec_pkg::FLOAT}, 8));
    alu0  = (r2 && len0 && inList(fn, {idec_pkg::MUL, idec_pkg::DIV, idec_pkg::MIN,
                                       idec_pkg::MAX, idec_pkg::R1, idec_pkg::SHIFTR}, 6))
            || inList(op, {idec_pkg::MEMNDX, idec_pkg::MULI, idec_pkg::DIVI,
                           idec_pkg::CSRRW}, 4);
    sync  = (r2 && len0 && (fn == idec_pkg::R1)
             && (ins[`R1_HI:`R1_LO] == idec_pkg::SYNC)) || brk || rti;
    sei   = r2 && len0 && (fn == idec_pkg::SEI);
    aluWr = (r2 && len0 && inList(fn, {idec_pkg::ADD, idec_pkg::SUB, idec_pkg::AND,
                                       idec_pkg::OR, idec_pkg::XOR, idec_pkg::MUL,
                                       idec_pkg::DIV, idec_pkg::MIN, idec_pkg::MAX,
                                       idec_pkg::SHIFTR, idec_pkg::R1, idec_pkg::SEI}, 12))
            || inList(op, {idec_pkg::ADDI, idec_pkg::MULI, idec_pkg::DIVI, idec_pkg::ANDI,
                           idec_pkg::ORI, idec_pkg::XORI, idec_pkg::JAL, idec_pkg::CALL,
                           idec_pkg::RET, idec_pkg::CSRRW, idec_pkg::LUI}, 11);
    ndx0  = (op == idec_pkg::MEMNDX) && len0;
    load  = inList(op, {idec_pkg::LB, idec_pkg::LBU, idec_pkg::Lx}, 3)
            || (ndx0 && inList(fn, {idec_pkg::LBX, idec_pkg::LBUX, idec_pkg::LCX,
                                    idec_pkg::LHX, idec_pkg::LWX}, 5));
    store = modelStore(ins);
    // Longer indexed forms still count as memory ops
    mem   = (op == idec_pkg::MEMNDX)
            || inList(op, {idec_pkg::LB, idec_pkg::LBU, idec_pkg::Lx, idec_pkg::SB,
                           idec_pkg::Sx, idec_pkg::INC, idec_pkg::CAS}, 7);
    casx  = ndx0 && (fn == idec_pkg::CASX);
    rmw   = (op == idec_pkg::CAS) || (op == idec_pkg::INC) || casx;
    memWr = load || (op == idec_pkg::CAS) || casx;
    konst = inList(op, {idec_pkg::ADDI, idec_pkg::MULI, idec_pkg::DIVI, idec_pkg::ANDI,
                        idec_pkg::ORI, idec_pkg::XORI, idec_pkg::LB, idec_pkg::LBU,
                        idec_pkg::Lx, idec_pkg::SB, idec_pkg::Sx, idec_pkg::INC,
                        idec_pkg::CAS, idec_pkg::JAL, idec_pkg::CALL, idec_pkg::RET}, 16);
    return {alu, alu0, (op == idec_pkg::FLOAT), flow,
            (op == idec_pkg::Bcc) || (op == idec_pkg::BEQI), (op == idec_pkg::JMP),
            jal, ret, brk, brk && (ins[23:20] == 4'h0), rti, jal || ret || brk || rti,
            sync, sei, load, store, mem, (op == idec_pkg::MEMNDX), rmw, konst,
            (aluWr || memWr) && (rt != 0), load && (rt == 0)};
endfunction

// Lx and Sx size field
function automatic logic [2:0] sizeCode(input logic [2:0] b);
    if (b == 3'b100)
        return idec_pkg::OCTA;
    else if (b[1:0] == 2'b10)
        return idec_pkg::TETRA;
    else if (b[0])
        return idec_pkg::WYDE;
    else
        return idec_pkg::OCTA;
endfunction

function automatic logic [2:0] modelSize(input logic [`INSN_W-1:0] ins);
    logic [5:0] op;
    logic [5:0] fn;
    logic [2:0] size;
    op   = ins[`OP_HI:`OP_LO];
    fn   = ins[`S2_HI:`S2_LO];
    size = idec_pkg::OCTA;
    if (inList(op, {idec_pkg::LB, idec_pkg::LBU, idec_pkg::SB}, 3))
        size = idec_pkg::BYTE;
    else if (op == idec_pkg::Lx)
        size = sizeCode(ins[20:18]);
    else if (op == idec_pkg::Sx)
        size = sizeCode(ins[15:13]);
    else if ((op == idec_pkg::MEMNDX) && (ins[`L2_HI:`L2_LO] == 2'b00))
    begin
        if (inList(fn, {idec_pkg::LBX, idec_pkg::LBUX, idec_pkg::SBX}, 3))
            size = idec_pkg::BYTE;
        else if ((fn == idec_pkg::LCX) || (fn == idec_pkg::SCX))
            size = idec_pkg::WYDE;
        else if ((fn == idec_pkg::LHX) || (fn == idec_pkg::SHX))
            size = idec_pkg::TETRA;
    end
    return size;
endfunction

function automatic logic [`CONST_W-1:0] modelConst(input logic [`INSN_W-1:0] ins,
                                                   input bit store);
    logic signed [29:0]         wide;
    logic signed [13:0]         narrow;
    logic signed [`CONST_W-1:0] result;
    wide   = store ? {ins[47:23], ins[17:13]} : ins[47:18];
    narrow = store ? {ins[31:23], ins[17:13]} : ins[31:18];
    if (ins[6])
        result = wide;
    else
        result = narrow;
    return result;
endfunction

function automatic logic [`LEN_W-1:0] modelLen(input logic [`INSN_W-1:0] ins);
    case (ins[`L2_HI:`L2_LO])
        2'b00:   return 3'd4;
        2'b01:   return 3'd6;
        default: return 3'd2;
    endcase
endfunction

`endif

/* tb_instrDecoder.sv */
/* Testbench for the instruction decode stage. Drives one random instruction
   per cycle and checks every registered output against the reference model. */
`timescale 1ns/10ps
`include "idec_defines.svh"

module tb_instrDecoder;

    localparam int NumTests   = 2000;
    localparam int CycleLimit = NumTests + 100;

    // Listed codes at six bits each
    localparam logic [25*6-1:0] OpList = {idec_pkg::BRK, idec_pkg::R2, idec_pkg::ADDI,
        idec_pkg::CSRRW, idec_pkg::MULI, idec_pkg::DIVI, idec_pkg::ANDI, idec_pkg::ORI,
        idec_pkg::XORI, idec_pkg::FLOAT, idec_pkg::LB, idec_pkg::SB, idec_pkg::MEMNDX,
        idec_pkg::JAL, idec_pkg::INC, idec_pkg::Lx, idec_pkg::LBU, idec_pkg::Sx,
        idec_pkg::LUI, idec_pkg::JMP, idec_pkg::CALL, idec_pkg::RET, idec_pkg::CAS,
        idec_pkg::Bcc, idec_pkg::BEQI};
    localparam logic [13*6-1:0] R2List = {idec_pkg::R1, idec_pkg::ADD, idec_pkg::SUB,
        idec_pkg::AND, idec_pkg::OR, idec_pkg::XOR, idec_pkg::SEI, idec_pkg::RTI,
        idec_pkg::MIN, idec_pkg::MAX, idec_pkg::SHIFTR, idec_pkg::MUL, idec_pkg::DIV};
    localparam logic [10*6-1:0] NdxList = {idec_pkg::LBX, idec_pkg::LBUX, idec_pkg::LCX,
        idec_pkg::LHX, idec_pkg::LWX, idec_pkg::SBX, idec_pkg::SCX, idec_pkg::SHX,
        idec_pkg::SWX, idec_pkg::CASX};

    logic                clk;
    logic                rstN_i;
    logic                idv_i;
    logic [`ID_W-1:0]    id_i;
    logic [`INSN_W-1:0]  instr_i;
    logic [`REG_W-1:0]   rt_i;
    logic                idv_o;
    logic [`ID_W-1:0]    id_o;
    logic                isAlu_o, alu0Only_o, isFpu_o, flowCtrl_o;
    logic                isBranch_o, isJmp_o, isJal_o, isRet_o;
    logic                isBrk_o, isIrq_o, isRti_o, branchTarget_o;
    logic                isSync_o, isSei_o;
    logic                isLoad_o, isStore_o, isMem_o, isMemNdx_o, isRmw_o;
    idec_pkg::memSize_e  memSize_o;
    logic [`CONST_W-1:0] const_o;
    logic                hasConst_o;
    logic [`LEN_W-1:0]   len_o;
    logic                regFileWrite_o, preload_o;

    `include "tb_decodeModel.svh"

    logic [31:0] rngState;
    int          cycleCount = 0;
    expect_t     expQ [$];

    instrDecoder u_instrDecoder (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic drawRand(output logic [31:0] r);
        rngState = xorshift32(rngState);
        r = rngState;
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic driveRandom();
        logic [31:0]        r0, r1, r2, r3;
        logic [`INSN_W-1:0] ins;
        logic [5:0]         op;
        expect_t            e;
        drawRand(r0);
        drawRand(r1);
        drawRand(r2);
        drawRand(r3);
        ins = {r1[15:0], r0};
        // Listed opcode three cycles in four
        if (r2[1:0] != 2'b11)
        begin
            op = OpList[(r2[15:8] % 25) * 6 +: 6];
            ins[`OP_HI:`OP_LO] = op;
            if (op == idec_pkg::R2)
                ins[`S2_HI:`S2_LO] = R2List[(r2[23:16] % 13) * 6 +: 6];
            else if (op == idec_pkg::MEMNDX)
                ins[`S2_HI:`S2_LO] = NdxList[(r2[23:16] % 10) * 6 +: 6];
            // Lean toward the base form
            if (r2[2])
                ins[`L2_HI:`L2_LO] = 2'b00;
            if (r2[3] && (op == idec_pkg::BRK))
                ins[23:20] = 4'h0;
            if (r2[3] && (op == idec_pkg::R2) && (ins[`S2_HI:`S2_LO] == idec_pkg::R1))
                ins[`R1_HI:`R1_LO] = idec_pkg::SYNC;
        end
        instr_i = ins;
        idv_i   = r3[3];
        id_i    = r3[8:4];
        rt_i    = (r3[2:0] == 3'b000) ? '0 : r3[13:9];
        e.idv   = idv_i;
        e.id    = id_i;
        e.flags = modelFlags(ins, rt_i);
        e.size  = modelSize(ins);
        e.konst = modelConst(ins, modelStore(ins));
        e.len   = modelLen(ins);
        expQ.push_back(e);
    endtask

    // ========================================================================
    // Checking
    // ========================================================================
    task automatic checkField(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic checkOutputs(input expect_t e);
        checkField("idv_o", idv_o, e.idv);
        checkField("id_o", id_o, e.id);
        checkField("isAlu_o", isAlu_o, e.flags[21]);
        checkField("alu0Only_o", alu0Only_o, e.flags[20]);
        checkField("isFpu_o", isFpu_o, e.flags[19]);
        checkField("flowCtrl_o", flowCtrl_o, e.flags[18]);
        checkField("isBranch_o", isBranch_o, e.flags[17]);
        checkField("isJmp_o", isJmp_o, e.flags[16]);
        checkField("isJal_o", isJal_o, e.flags[15]);
        checkField("isRet_o", isRet_o, e.flags[14]);
        checkField("isBrk_o", isBrk_o, e.flags[13]);
        checkField("isIrq_o", isIrq_o, e.flags[12]);
        checkField("isRti_o", isRti_o, e.flags[11]);
        checkField("branchTarget_o", branchTarget_o, e.flags[10]);
        checkField("isSync_o", isSync_o, e.flags[9]);
        checkField("isSei_o", isSei_o, e.flags[8]);
        checkField("isLoad_o", isLoad_o, e.flags[7]);
        checkField("isStore_o", isStore_o, e.flags[6]);
        checkField("isMem_o", isMem_o, e.flags[5]);
        checkField("isMemNdx_o", isMemNdx_o, e.flags[4]);
        checkField("isRmw_o", isRmw_o, e.flags[3]);
        checkField("hasConst_o", hasConst_o, e.flags[2]);
        checkField("regFileWrite_o", regFileWrite_o, e.flags[1]);
        checkField("preload_o", preload_o, e.flags[0]);
        checkField("memSize_o", memSize_o, e.size);
        checkField("const_o", const_o, e.konst);
        checkField("len_o", len_o, e.len);
    endtask

    initial
    begin
        rngState = 32'd74;
        rstN_i   = 1'b0;
        // Drive non-zero inputs while reset is held
        idv_i    = 1'b1;
        id_i     = '1;
        instr_i  = '1;
        rt_i     = '1;
        @(posedge clk);
        #1;
        // Cleared state has memSize at BYTE, which encodes as zero
        checkOutputs('0);
        // Break opcode raises the flow-control flags
        instr_i  = '0;
        @(posedge clk);
        #1;
        checkOutputs('0);
        rstN_i = 1'b1;
        driveRandom();
        for (int n = 1; n < NumTests; n++)
        begin
            @(posedge clk);
            #1;
            checkOutputs(expQ.pop_front());
            driveRandom();
        end
        @(posedge clk);
        #1;
        checkOutputs(expQ.pop_front());
        $display("Test passed");
        $finish;
    end

endmodule
